/* detAccel_config.svh */
// size and width macros for the determinant accelerator, included by the package and the RTL
`ifndef DET_ACCEL_CONFIG_SVH
`define DET_ACCEL_CONFIG_SVH

// largest matrix side the unit accepts
`define DET_MAX_DIM 6

// one word per element of the largest matrix
`define DET_RAM_DEPTH 36
`define DET_IDX_W 6

// bus side
`define DET_ADDR_W 24   // byte address
`define DET_DATA_W 32   // data word, also the element width

`endif

/* detPkg.sv */
// shared types of the determinant accelerator, imported by the RTL modules and the testbench
`include "detAccel_config.svh"

package detPkg;

    typedef logic signed [`DET_DATA_W-1:0] element_t;   // entry or determinant
    typedef logic [`DET_IDX_W-1:0] ramIndex_t;
    typedef logic [2:0] dim_t;

    // one determinant request
    typedef struct packed {
        logic [`DET_ADDR_W-1:0] base;   // byte address of element 0,0
        dim_t dim;
    } job_t;

    typedef struct packed {
        logic en;
        ramIndex_t addr;
        element_t data;
    } ramWrite_t;

    // codes returned on the command port
    typedef enum logic [31:0] {
        statReady     = 32'd0,
        statLoading   = 32'd1,
        statComputing = 32'd2,
        statPending   = 32'd3,
        statRejected  = 32'd98,
        statAccepted  = 32'd99
    } status_e;

endpackage

/* matrixRam.sv */
// matrix storage, one write port and one read port with a registered output
`include "detAccel_config.svh"

module matrixRam import detPkg::*; (
    input  logic clk,
    input  ramWrite_t wr,
    input  ramIndex_t rdAddr,
    output element_t rdData
);
    element_t mem [`DET_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr] <= wr.data;
        rdData <= mem[rdAddr];   // data valid one cycle after rdAddr
    end

endmodule

/* seqDivider.sv */
// sequential signed divider for a 64-bit dividend and 32-bit divisor with one quotient bit per cycle
`include "detAccel_config.svh"

module seqDivider import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic divStart,
    input  logic signed [63:0] dividend,
    input  element_t divisor,
    output element_t quotient,
    output logic divDone
);
    localparam int W = `DET_DATA_W;

    logic [5:0] count;      // iterations left plus the sign step
    logic [W-1:0] rem;
    logic [W-1:0] quo;      // dividend low half shifts out as quotient bits shift in
    logic [W-1:0] dvs;
    logic neg;
    logic [63:0] mag;
    logic [W:0] shifted;

    // magnitudes only as the quotient fits W bits
    assign mag = dividend[63] ? 64'(-dividend) : 64'(dividend);
    assign shifted = {rem, quo[W-1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                rem <= mag[63:W];
                quo <= mag[W-1:0];
                dvs <= divisor[W-1] ? W'(-divisor) : W'(divisor);
                neg <= dividend[63] ^ divisor[W-1];
                count <= 6'(W + 1);
            end else if (count > 6'd1) begin
                if (shifted >= {1'b0, dvs}) begin
                    rem <= W'(shifted - {1'b0, dvs});
                    quo <= {quo[W-2:0], 1'b1};
                end else begin
                    rem <= shifted[W-1:0];
                    quo <= {quo[W-2:0], 1'b0};
                end
                count <= count - 1'b1;
            end else if (count == 6'd1) begin
                quotient <= neg ? -quo : quo;   // restore the sign
                divDone <= 1'b1;
                count <= '0;
            end
        end
    end

endmodule

/* matrixLoader.sv */
// pipelined bus read master, streams dim squared words from memory into the matrix RAM
`include "detAccel_config.svh"

module matrixLoader import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  job_t job,
    input  logic loadStart,
    input  logic waitRequest,
    input  element_t readData,
    input  logic readDataValid,
    output logic [`DET_ADDR_W-1:0] address,
    output logic read,
    output ramWrite_t ramWr,
    output logic loadDone
);
    ramIndex_t reqCount;    // requests accepted by the bus
    ramIndex_t rcvCount;    // words written to RAM
    ramIndex_t lastIdx;     // dim squared minus one
    logic active;

    always_ff @(posedge clk) begin
        if (rst) begin
            read <= 1'b0;
            active <= 1'b0;
            reqCount <= '0;
            rcvCount <= '0;
            ramWr.en <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            // one cycle after the final write
            loadDone <= ramWr.en && (ramWr.addr == lastIdx);

            if (loadStart) begin
                address <= job.base;
                read <= 1'b1;
                active <= 1'b1;
                reqCount <= '0;
                rcvCount <= '0;
                lastIdx <= ramIndex_t'(job.dim) * ramIndex_t'(job.dim) - 1'b1;
            end else if (read && !waitRequest) begin
                address <= address + `DET_ADDR_W'(4);
                reqCount <= reqCount + 1'b1;
                if (reqCount == lastIdx)
                    read <= 1'b0;   // all requests out
            end

            // receive side runs independently of back-pressure
            ramWr.en <= readDataValid && active;
            ramWr.addr <= rcvCount;
            ramWr.data <= readData;
            if (readDataValid && active) begin
                rcvCount <= rcvCount + 1'b1;
                if (rcvCount == lastIdx)
                    active <= 1'b0;
            end
        end
    end

endmodule

/* bareissEngine.sv */
// fraction-free elimination of the matrix in RAM through a row pointer table, returns the determinant
`include "detAccel_config.svh"

module bareissEngine import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic calcStart,
    input  dim_t dim,
    input  element_t rdData,
    input  element_t quotient,
    input  logic divDone,
    output ramIndex_t rdAddr,
    output ramWrite_t ramWr,
    output logic divStart,
    output logic signed [63:0] dividend,
    output element_t divisor,
    output logic calcDone,
    output element_t calcResult
);
    typedef enum logic [3:0] {
        sIdle, sPivAddr, sPivGet, sSrchAddr, sSrchGet,
        sElemIJ, sElemIK, sElemKJ, sElemMul, sElemDiv, sFinAddr, sFinGet
    } state_e;

    state_e state;
    ramIndex_t rowPtr [`DET_MAX_DIM];   // RAM index of column 0 per logical row
    dim_t dimReg, lastRow;
    dim_t k, i, j, r;       // pivot column, target row, target column, search row
    element_t pivot, prev;  // current and previous pivot
    element_t aij, aik;
    logic negate;           // odd number of swaps

    function automatic ramIndex_t addrOf(ramIndex_t base, dim_t col);
        return base + ramIndex_t'(col);
    endfunction

    assign lastRow = dimReg - 1'b1;

    always_comb begin
        case (state)
            sPivAddr:  rdAddr = addrOf(rowPtr[k], k);
            sSrchAddr: rdAddr = addrOf(rowPtr[r], k);
            sElemIJ:   rdAddr = addrOf(rowPtr[i], j);
            sElemIK:   rdAddr = addrOf(rowPtr[i], k);
            sElemKJ:   rdAddr = addrOf(rowPtr[k], j);
            sFinAddr:  rdAddr = addrOf(rowPtr[lastRow], lastRow);
            default:   rdAddr = '0;
        endcase
    end

    // quotient goes straight back, so the next read never meets a pending write
    always_comb begin
        ramWr.en = (state == sElemDiv) && divDone;
        ramWr.addr = addrOf(rowPtr[i], j);
        ramWr.data = quotient;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
            divStart <= 1'b0;
            calcDone <= 1'b0;
        end else begin
            divStart <= 1'b0;
            calcDone <= 1'b0;
            case (state)
                sIdle: if (calcStart) begin
                    for (int n = 0; n < `DET_MAX_DIM; n++)
                        rowPtr[n] <= ramIndex_t'(n * dim);
                    dimReg <= dim;
                    k <= '0;
                    prev <= 32'sd1;
                    negate <= 1'b0;
                    state <= sPivAddr;
                end
                sPivAddr: state <= sPivGet;
                sPivGet: begin
                    pivot <= rdData;
                    i <= k + 1'b1;
                    j <= k + 1'b1;
                    r <= k + 1'b1;
                    state <= (rdData != 0) ? sElemIJ : sSrchAddr;
                end
                sSrchAddr: state <= sSrchGet;
                sSrchGet: begin
                    if (rdData != 0) begin
                        pivot <= rdData;
                        rowPtr[k] <= rowPtr[r];
                        rowPtr[r] <= rowPtr[k];
                        negate <= ~negate;
                        state <= sElemIJ;
                    end else if (r == lastRow) begin
                        calcResult <= '0;   // whole column zero, singular
                        calcDone <= 1'b1;
                        state <= sIdle;
                    end else begin
                        r <= r + 1'b1;
                        state <= sSrchAddr;
                    end
                end
                sElemIJ: state <= sElemIK;
                sElemIK: begin
                    aij <= rdData;
                    state <= sElemKJ;
                end
                sElemKJ: begin
                    aik <= rdData;
                    state <= sElemMul;
                end
                sElemMul: begin
                    dividend <= aij * pivot - aik * rdData;   // rdData holds akj
                    divisor <= prev;
                    divStart <= 1'b1;
                    state <= sElemDiv;
                end
                sElemDiv: if (divDone) begin
                    if (j != lastRow) begin
                        j <= j + 1'b1;
                        state <= sElemIJ;
                    end else if (i != lastRow) begin
                        i <= i + 1'b1;
                        j <= k + 1'b1;
                        state <= sElemIJ;
                    end else begin
                        prev <= pivot;
                        k <= k + 1'b1;
                        state <= (dim_t'(k + 1'b1) == lastRow) ? sFinAddr : sPivAddr;
                    end
                end
                sFinAddr: state <= sFinGet;
                sFinGet: begin
                    calcResult <= negate ? -rdData : rdData;
                    calcDone <= 1'b1;
                    state <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

endmodule

/* cmdControl.sv */
// command decode and stage tracking that answers every start and hands the result to the irq port
`include "detAccel_config.svh"

module cmdControl import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [31:0] dataa,
    input  logic [31:0] datab,
    input  logic loadDone,
    input  logic calcDone,
    input  element_t calcResult,
    input  logic resultRead,
    output logic done,
    output status_e result,
    output job_t job,
    output logic loadStart,
    output logic calcStart,
    output logic computing,
    output logic irq,
    output element_t resultReadData
);
    typedef enum logic [1:0] {stIdle, stLoading, stComputing, stPending} stage_e;

    stage_e stage;
    status_e stageCode;
    element_t det;      // latched determinant
    logic readAck;      // result taken so release next cycle

    always_comb begin
        case (stage)
            stLoading:   stageCode = statLoading;
            stComputing: stageCode = statComputing;
            stPending:   stageCode = statPending;
            default:     stageCode = statReady;
        endcase
    end

    assign computing = (stage == stComputing);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= stIdle;
            done <= 1'b0;
            result <= statReady;
            loadStart <= 1'b0;
            calcStart <= 1'b0;
            irq <= 1'b0;
            readAck <= 1'b0;
        end else begin
            done <= start;
            result <= statReady;
            loadStart <= 1'b0;
            calcStart <= 1'b0;
            readAck <= 1'b0;

            if (start) begin
                if (datab <= 32'd1 || stage != stIdle) begin
                    result <= stageCode;   // query or busy
                end else if (datab > 32'(`DET_MAX_DIM)) begin
                    result <= statRejected;
                end else begin
                    result <= statAccepted;
                    job.base <= dataa[`DET_ADDR_W-1:0];
                    job.dim <= datab[2:0];
                    loadStart <= 1'b1;
                    stage <= stLoading;
                end
            end

            case (stage)
                stLoading: if (loadDone) begin
                    calcStart <= 1'b1;
                    stage <= stComputing;
                end
                stComputing: if (calcDone) begin
                    det <= calcResult;
                    irq <= 1'b1;
                    stage <= stPending;
                end
                stPending: begin
                    if (readAck) begin
                        stage <= stIdle;
                    end else if (resultRead) begin
                        resultReadData <= det;
                        irq <= 1'b0;
                        readAck <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* detAccel.sv */
// determinant accelerator top, command port plus bus read master plus result port with irq
`include "detAccel_config.svh"

module detAccel import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic [31:0] dataa,
    input  logic [31:0] datab,
    output logic done,
    output status_e result,
    output logic [`DET_ADDR_W-1:0] address,
    output logic read,
    input  element_t readData,
    input  logic readDataValid,
    input  logic waitRequest,
    input  logic resultRead,
    output element_t resultReadData,
    output logic irq
);
    job_t job;
    logic loadStart, loadDone;
    logic calcStart, calcDone, computing;
    element_t calcResult;

    ramWrite_t loadWr, engWr, ramWr;
    ramIndex_t rdAddr;
    element_t rdData;

    logic divStart, divDone;
    logic signed [63:0] dividend;
    element_t divisor, quotient;

    // loader owns the RAM until compute begins
    assign ramWr = computing ? engWr : loadWr;

    cmdControl i_cmd (
        .clk(clk), .rst(rst), .start(start), .dataa(dataa), .datab(datab),
        .loadDone(loadDone), .calcDone(calcDone), .calcResult(calcResult),
        .resultRead(resultRead), .done(done), .result(result), .job(job),
        .loadStart(loadStart), .calcStart(calcStart), .computing(computing),
        .irq(irq), .resultReadData(resultReadData)
    );

    matrixLoader i_loader (
        .clk(clk), .rst(rst), .job(job), .loadStart(loadStart),
        .waitRequest(waitRequest), .readData(readData), .readDataValid(readDataValid),
        .address(address), .read(read), .ramWr(loadWr), .loadDone(loadDone)
    );

    matrixRam i_ram (.clk(clk), .wr(ramWr), .rdAddr(rdAddr), .rdData(rdData));

    bareissEngine i_engine (
        .clk(clk), .rst(rst), .calcStart(calcStart), .dim(job.dim), .rdData(rdData),
        .quotient(quotient), .divDone(divDone), .rdAddr(rdAddr), .ramWr(engWr),
        .divStart(divStart), .dividend(dividend), .divisor(divisor),
        .calcDone(calcDone), .calcResult(calcResult)
    );

    seqDivider i_div (
        .clk(clk), .rst(rst), .divStart(divStart), .dividend(dividend),
        .divisor(divisor), .quotient(quotient), .divDone(divDone)
    );

endmodule

/* busMemModel.sv */
// testbench bus memory, random waitrequest and in-order read data after a random latency
`include "detAccel_config.svh"

module busMemModel import detPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [`DET_ADDR_W-1:0] address,
    input  logic read,
    input  logic stall,         // back-pressure request from the testbench
    input  logic [1:0] delay,   // extra read latency
    output logic waitRequest,
    output element_t readData,
    output logic readDataValid
);
    element_t mem [256];    // word index from address bits 9..2
    element_t dataQ [$];
    int dueQ [$];           // cycle at which each word may return
    int cycle;

    assign waitRequest = read && stall;

    always @(posedge clk) begin
        readDataValid <= 1'b0;
        if (rst) begin
            dataQ.delete();
            dueQ.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (read && !waitRequest) begin
                dataQ.push_back(mem[address[9:2]]);
                dueQ.push_back(cycle + 1 + int'(delay));
            end
            // front of the queue only, keeps the data in order
            if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
                readData <= dataQ.pop_front();
                void'(dueQ.pop_front());
                readDataValid <= 1'b1;
            end
        end
    end

endmodule

/* detAccel_tb.sv */
// testbench for the determinant accelerator that checks random matrices against a cofactor model
`include "detAccel_config.svh"

module detAccel_tb import detPkg::*; ();

    logic clk = 1'b0;
    logic rst, start, resultRead;
    logic stall = 1'b0;
    logic [1:0] delay = 2'd0;
    logic [31:0] dataa, datab;
    logic done, read, readDataValid, waitRequest, irq;
    logic [`DET_ADDR_W-1:0] address;
    status_e result;
    element_t readData, resultReadData;
    integer seed = 32'h56df_127e;
    int mat [`DET_MAX_DIM][`DET_MAX_DIM];   // matrix of the current job

    detAccel i_dut (.*);
    busMemModel i_mem (.*);

    always #10 clk = ~clk;

    // new bus back-pressure and latency draw every cycle
    always @(negedge clk) begin
        {stall, delay} = 3'($random(seed));
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareStatus(input string name, input status_e got, input status_e exp);
        if (got !== exp)
            stopWithError($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                $time, name, got, exp));
    endtask

    task automatic compareDet(input string name, input element_t got, input element_t exp);
        if (got !== exp)
            stopWithError($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                $time, name, got, exp));
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stopWithError($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, name, got, exp));
    endtask

    // laplace expansion along the last row with top-row minors kept per column subset
    function automatic longint modelDet(input int n);
        longint minor [64];
        int p;
        int idx;
        longint term;
        minor[0] = 1;
        for (int mask = 1; mask < (1 << n); mask++) begin
            p = $countones(mask);
            idx = 0;
            minor[mask] = 0;
            for (int c = 0; c < n; c++) begin
                if (mask[c]) begin
                    term = mat[p-1][c] * minor[mask & ~(1 << c)];
                    if ((p - 1 + idx) % 2 == 1)
                        minor[mask] -= term;
                    else
                        minor[mask] += term;
                    idx++;
                end
            end
        end
        return minor[(1 << n) - 1];
    endfunction

    function automatic logic [31:0] randomBase();
        return {8'h00, 24'($random(seed))} & 32'h00ff_fffc;   // word aligned
    endfunction

    task automatic randomMatrix(input int n);
        for (int r = 0; r < n; r++)
            for (int c = 0; c < n; c++)
                mat[r][c] = ($random(seed) & 15) - 8;   // -8..7
    endtask

    task automatic writeMatrix(input int n, input logic [31:0] base);
        for (int r = 0; r < n; r++)
            for (int c = 0; c < n; c++)
                i_mem.mem[8'(base[9:2] + r * n + c)] = mat[r][c];   // wraps like the bus
    endtask

    // start pulse on the command port with done due one cycle later
    task automatic issueStart(input logic [31:0] base, input logic [31:0] d,
                              output status_e code);
        @(negedge clk);
        start = 1'b1;
        dataa = base;
        datab = d;
        @(negedge clk);
        start = 1'b0;
        compareFlag("done", done, 1'b1);
        code = result;
    endtask

    task automatic runJob(input int n, input logic [31:0] base, input bit pollStages);
        status_e code;
        status_e expCode;
        element_t expDet;
        int waitCount;
        expDet = element_t'(modelDet(n));
        writeMatrix(n, base);
        issueStart(base, 32'(n), code);
        compareStatus("result", code, statAccepted);
        if (pollStages) begin
            expCode = statLoading;   // first poll still loading, then codes only move forward
            waitCount = 0;
            do begin
                issueStart(base, (waitCount % 2 == 1) ? 32'd5 : 32'd1, code);
                if (waitCount > 0 && code != expCode && expCode != statPending)
                    expCode = status_e'(expCode + 1);
                compareStatus("result", code, expCode);
                waitCount++;
                if (waitCount > 5000)
                    stopWithError("timeout while polling the stage codes");
            end while (code != statPending);
            compareFlag("irq", irq, 1'b1);
        end
        waitCount = 0;
        while (irq !== 1'b1) begin
            @(negedge clk);
            waitCount++;
            if (waitCount > 20000)
                stopWithError("timeout waiting for irq after a job start");
        end
        resultRead = 1'b1;
        @(negedge clk);
        resultRead = 1'b0;
        compareFlag("irq", irq, 1'b0);
        compareDet("resultReadData", resultReadData, expDet);
        issueStart(base, 32'd0, code);   // unit idle again
        compareStatus("result", code, statReady);
    endtask

    initial begin
        status_e code;
        int n;
        rst = 1'b1;
        start = 1'b0;
        dataa = '0;
        datab = '0;
        resultRead = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        compareFlag("irq", irq, 1'b0);
        compareFlag("read", read, 1'b0);
        issueStart(32'd0, 32'd1, code);
        compareStatus("result", code, statReady);

        for (int t = 0; t < 20; t++) begin
            n = 2 + (($random(seed) & 32'h7fff) % 5);
            randomMatrix(n);
            runJob(n, randomBase(), t % 2 == 0);
        end

        // zero pivots and singular matrices
        for (int t = 0; t < 12; t++) begin
            n = 2 + t % 5;
            randomMatrix(n);
            case (t % 4)
                0: begin   // swap with the last row at column 0
                    for (int r = 0; r < n - 1; r++)
                        mat[r][0] = 0;
                    mat[n-1][0] = 3;
                end
                1: begin   // second pivot becomes zero
                    mat[0][0] = 2;
                    mat[1][0] = mat[0][0];
                    mat[1][1] = mat[0][1];
                end
                2: begin
                    for (int c = 0; c < n; c++)
                        mat[n-1][c] = mat[0][c];
                end
                default: begin
                    for (int r = 0; r < n; r++)
                        mat[r][0] = 0;
                end
            endcase
            runJob(n, randomBase(), t % 3 == 0);
        end

        issueStart(randomBase(), 32'd7, code);
        compareStatus("result", code, statRejected);
        issueStart(randomBase(), 32'd200, code);   // low bits zero but still too big
        compareStatus("result", code, statRejected);
        repeat (3) begin
            @(negedge clk);
            compareFlag("read", read, 1'b0);
        end
        compareFlag("irq", irq, 1'b0);
        issueStart(32'd0, 32'd1, code);
        compareStatus("result", code, statReady);

        randomMatrix(6);
        runJob(6, randomBase(), 1'b1);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
detPkg.sv
matrixRam.sv
seqDivider.sv
matrixLoader.sv
bareissEngine.sv
cmdControl.sv
detAccel.sv
busMemModel.sv
detAccel_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module detAccel_tb -f all.f
	out=$$(./obj_dir/VdetAccel_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
